// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int unsigned xlen = 32;
  localparam int unsigned reg_addr_w = 5;

  // major opcodes of the kept RV32I subset
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // seventeen operations, so five bits
  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and,
    alu_pass_b,
    alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bge_u
  } alu_op_e;

  typedef enum logic [2:0] {
    kind_alu, kind_jal, kind_jalr, kind_branch, kind_illegal
  } inst_kind_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered over the word
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t      r;
    i_fmt_t      i;
    s_fmt_t      s;
    b_fmt_t      b;
    u_fmt_t      u;
    j_fmt_t      j;
    logic [31:0] raw;
  } inst_u;

endpackage

`default_nettype wire

// File: rv_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_issue_if;
  logic                          valid;
  logic                          ready;
  logic [rv_pkg::xlen-1:0]       pc;
  rv_pkg::inst_kind_e            kind;
  rv_pkg::alu_op_e               alu_op;
  logic [rv_pkg::xlen-1:0]       operand_a;
  logic [rv_pkg::xlen-1:0]       operand_b;
  logic [rv_pkg::xlen-1:0]       rs1_val;
  logic [rv_pkg::xlen-1:0]       rs2_val;
  logic [rv_pkg::xlen-1:0]       imm;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic                          wen;

  modport source (
    output valid, pc, kind, alu_op, operand_a, operand_b, rs1_val, rs2_val, imm, rd, wen,
    input  ready
  );

  modport sink (
    input  valid, pc, kind, alu_op, operand_a, operand_b, rs1_val, rs2_val, imm, rd, wen,
    output ready
  );
endinterface

`default_nettype wire

// File: rv_result_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_result_if;
  logic                          valid;
  logic                          ready;
  logic [rv_pkg::xlen-1:0]       pc;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic                          wen;
  logic [rv_pkg::xlen-1:0]       data;
  logic [rv_pkg::xlen-1:0]       next_pc;
  logic                          illegal;

  modport source (
    output valid, pc, rd, wen, data, next_pc, illegal,
    input  ready
  );

  modport sink (
    input  valid, pc, rd, wen, data, next_pc, illegal,
    output ready
  );
endinterface

`default_nettype wire

// File: inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic [rv_pkg::xlen-1:0] in_pc,
  input  logic [rv_pkg::xlen-1:0] in_inst,
  output logic                    in_ready,
  output logic                    q_valid,
  output logic [rv_pkg::xlen-1:0] q_pc,
  output logic [rv_pkg::xlen-1:0] q_inst,
  input  logic                    q_ready
);
  logic [rv_pkg::xlen-1:0] pc_mem [2];
  logic [rv_pkg::xlen-1:0] inst_mem [2];
  logic                    wr_ptr;
  logic                    rd_ptr;
  logic [1:0]              count;
  logic                    push;
  logic                    pop;

  assign in_ready = (count != 2'd2);
  assign q_valid  = (count != 2'd0);
  assign push     = in_valid && in_ready;
  assign pop      = q_valid && q_ready;
  assign q_pc     = pc_mem[rd_ptr];
  assign q_inst   = inst_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      // simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      pc_mem[wr_ptr]   <= in_pc;
      inst_mem[wr_ptr] <= in_inst;
    end
  end
endmodule

`default_nettype wire

// File: rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          q_valid,
  input  logic [rv_pkg::xlen-1:0]       q_pc,
  input  logic [rv_pkg::xlen-1:0]       q_inst,
  output logic                          q_ready,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [rv_pkg::xlen-1:0]       rs1_val,
  input  logic [rv_pkg::xlen-1:0]       rs2_val,
  input  logic                          wb_en,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  rv_issue_if.source                    issue
);
  logic                    ir_valid;
  logic [rv_pkg::xlen-1:0] ir_pc;
  rv_pkg::inst_u           ir;
  rv_pkg::inst_kind_e      kind;
  rv_pkg::alu_op_e         alu_op;
  logic [rv_pkg::xlen-1:0] imm;
  logic                    use_rs1;
  logic                    use_rs2;
  logic                    use_imm;
  logic                    a_pc;
  logic                    a_zero;
  logic                    is_reg;
  logic                    alt;
  logic                    f7_ok;
  logic                    wen;
  logic                    hazard;
  logic                    fire;
  logic [31:0]             pending;
  logic [31:0]             set_mask;
  logic [31:0]             clr_mask;

  assign is_reg = (ir.r.opcode == rv_pkg::op_reg);
  assign alt    = (ir.r.funct7 == 7'b0100000);
  // alternate funct7 only for sub and the arithmetic shift
  assign f7_ok  = (ir.r.funct7 == 7'b0) ||
                  (alt && (ir.r.funct3 == 3'b101 || (ir.r.funct3 == 3'b000 && is_reg)));

  always_comb begin
    kind    = rv_pkg::kind_illegal;
    alu_op  = rv_pkg::alu_add;
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_imm = 1'b0;
    a_pc    = 1'b0;
    a_zero  = 1'b0;
    case (ir.r.opcode)
      rv_pkg::op_lui, rv_pkg::op_auipc: begin
        kind    = rv_pkg::kind_alu;
        alu_op  = (ir.u.opcode == rv_pkg::op_lui) ? rv_pkg::alu_pass_b : rv_pkg::alu_add;
        imm     = {ir.u.imm, 12'b0};
        use_imm = 1'b1;
        a_zero  = (ir.u.opcode == rv_pkg::op_lui);
        a_pc    = (ir.u.opcode == rv_pkg::op_auipc);
      end
      rv_pkg::op_jal: begin
        kind = rv_pkg::kind_jal;
        imm  = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12, ir.j.imm_11,
                ir.j.imm_10_1, 1'b0};
      end
      rv_pkg::op_jalr: begin
        if (ir.i.funct3 == 3'b000) kind = rv_pkg::kind_jalr;
        imm     = {{20{ir.i.imm[11]}}, ir.i.imm};
        use_rs1 = 1'b1;
      end
      rv_pkg::op_branch: begin
        kind    = rv_pkg::kind_branch;
        imm     = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11, ir.b.imm_10_5,
                   ir.b.imm_4_1, 1'b0};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (ir.b.funct3)
          3'b000:  alu_op = rv_pkg::alu_beq;
          3'b001:  alu_op = rv_pkg::alu_bne;
          3'b100:  alu_op = rv_pkg::alu_blt;
          3'b101:  alu_op = rv_pkg::alu_bge;
          3'b110:  alu_op = rv_pkg::alu_bltu;
          3'b111:  alu_op = rv_pkg::alu_bge_u;
          default: kind = rv_pkg::kind_illegal;
        endcase
      end
      rv_pkg::op_imm, rv_pkg::op_reg: begin
        kind    = rv_pkg::kind_alu;
        imm     = {{20{ir.i.imm[11]}}, ir.i.imm};
        use_rs1 = 1'b1;
        use_rs2 = is_reg;
        use_imm = !is_reg;
        case (ir.r.funct3)
          3'b000:  alu_op = (alt && is_reg) ? rv_pkg::alu_sub : rv_pkg::alu_add;
          3'b001:  alu_op = rv_pkg::alu_sll;
          3'b010:  alu_op = rv_pkg::alu_slt;
          3'b011:  alu_op = rv_pkg::alu_sltu;
          3'b100:  alu_op = rv_pkg::alu_xor;
          3'b101:  alu_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
          3'b110:  alu_op = rv_pkg::alu_or;
          default: alu_op = rv_pkg::alu_and;
        endcase
        // immediate forms only constrain funct7 on shifts
        if (!f7_ok && (is_reg || ir.r.funct3 == 3'b001 || ir.r.funct3 == 3'b101)) begin
          kind = rv_pkg::kind_illegal;
        end
      end
      default: kind = rv_pkg::kind_illegal;
    endcase
    // unknown words wait on nothing
    if (kind == rv_pkg::kind_illegal) begin
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
    end
  end

  assign rs1_addr = ir.r.rs1;
  assign rs2_addr = ir.r.rs2;
  assign wen = (kind == rv_pkg::kind_alu || kind == rv_pkg::kind_jal ||
                kind == rv_pkg::kind_jalr) && (ir.r.rd != '0);

  // a second writer of a pending register waits too
  assign hazard = (use_rs1 && pending[rs1_addr]) ||
                  (use_rs2 && pending[rs2_addr]) ||
                  (wen && pending[ir.r.rd]);

  assign issue.valid     = ir_valid && !hazard;
  assign issue.pc        = ir_pc;
  assign issue.kind      = kind;
  assign issue.alu_op    = alu_op;
  assign issue.operand_a = a_zero ? '0 : (a_pc ? ir_pc : rs1_val);
  assign issue.operand_b = use_imm ? imm : rs2_val;
  assign issue.rs1_val   = rs1_val;
  assign issue.rs2_val   = rs2_val;
  assign issue.imm       = imm;
  assign issue.rd        = ir.r.rd;
  assign issue.wen       = wen;

  assign fire    = issue.valid && issue.ready;
  assign q_ready = !ir_valid || fire;

  always_ff @(posedge clock) begin
    if (reset) begin
      ir_valid <= 1'b0;
    end else if (q_ready) begin
      ir_valid <= q_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (q_valid && q_ready) begin
      ir_pc  <= q_pc;
      ir.raw <= q_inst;
    end
  end

  // a set wins over a clear of the same register
  assign set_mask = (fire && wen) ? (32'd1 << ir.r.rd) : 32'd0;
  assign clr_mask = wb_en ? (32'd1 << wb_rd) : 32'd0;

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr_mask) | set_mask;
    end
  end
endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::xlen-1:0]       rs1_val,
  output logic [rv_pkg::xlen-1:0]       rs2_val,
  input  logic                          wb_en,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_data
);
  // x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:31];

  assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clock) begin
    if (reset) begin
      // architectural state starts at zero
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end
endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  logic        clock,
  input  logic        reset,
  rv_issue_if.sink    issue,
  rv_result_if.source result
);
  logic [rv_pkg::xlen-1:0] alu_res;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] target;
  logic [rv_pkg::xlen-1:0] data;
  logic [rv_pkg::xlen-1:0] next_pc;
  logic [4:0]              shamt;
  logic                    cond;
  logic                    taken;
  logic                    wen;

  assign shamt = issue.operand_b[4:0];

  always_comb begin
    case (issue.alu_op)
      rv_pkg::alu_add:    alu_res = issue.operand_a + issue.operand_b;
      rv_pkg::alu_sub:    alu_res = issue.operand_a - issue.operand_b;
      rv_pkg::alu_sll:    alu_res = issue.operand_a << shamt;
      rv_pkg::alu_slt:    alu_res = {31'b0, $signed(issue.operand_a) < $signed(issue.operand_b)};
      rv_pkg::alu_sltu:   alu_res = {31'b0, issue.operand_a < issue.operand_b};
      rv_pkg::alu_xor:    alu_res = issue.operand_a ^ issue.operand_b;
      rv_pkg::alu_srl:    alu_res = issue.operand_a >> shamt;
      rv_pkg::alu_sra:    alu_res = $unsigned($signed(issue.operand_a) >>> shamt);
      rv_pkg::alu_or:     alu_res = issue.operand_a | issue.operand_b;
      rv_pkg::alu_and:    alu_res = issue.operand_a & issue.operand_b;
      rv_pkg::alu_pass_b: alu_res = issue.operand_b;
      default:            alu_res = '0;
    endcase
  end

  // branch compares look at the raw register values
  always_comb begin
    case (issue.alu_op)
      rv_pkg::alu_beq:   cond = (issue.rs1_val == issue.rs2_val);
      rv_pkg::alu_bne:   cond = (issue.rs1_val != issue.rs2_val);
      rv_pkg::alu_blt:   cond = ($signed(issue.rs1_val) < $signed(issue.rs2_val));
      rv_pkg::alu_bge:   cond = ($signed(issue.rs1_val) >= $signed(issue.rs2_val));
      rv_pkg::alu_bltu:  cond = (issue.rs1_val < issue.rs2_val);
      rv_pkg::alu_bge_u: cond = (issue.rs1_val >= issue.rs2_val);
      default:           cond = 1'b0;
    endcase
  end

  assign pc_plus4 = issue.pc + 32'd4;
  assign target   = (issue.kind == rv_pkg::kind_jalr) ?
                    ((issue.rs1_val + issue.imm) & ~32'd1) : (issue.pc + issue.imm);
  assign taken    = (issue.kind == rv_pkg::kind_jal) || (issue.kind == rv_pkg::kind_jalr) ||
                    ((issue.kind == rv_pkg::kind_branch) && cond);
  assign next_pc  = taken ? target : pc_plus4;
  assign data     = (issue.kind == rv_pkg::kind_alu) ? alu_res :
                    (taken && issue.kind != rv_pkg::kind_branch) ? pc_plus4 : '0;
  assign wen      = issue.wen && (issue.kind != rv_pkg::kind_branch) &&
                    (issue.kind != rv_pkg::kind_illegal);

  assign issue.ready = !result.valid || result.ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      result.valid <= 1'b0;
    end else if (issue.ready) begin
      result.valid <= issue.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (issue.valid && issue.ready) begin
      result.pc      <= issue.pc;
      result.rd      <= issue.rd;
      result.wen     <= wen;
      result.data    <= data;
      result.next_pc <= next_pc;
      result.illegal <= (issue.kind == rv_pkg::kind_illegal);
    end
  end
endmodule

`default_nettype wire

// File: retire_port.sv
`timescale 1ns/1ps
`default_nettype none

module retire_port (
  input  logic                          clock,
  input  logic                          reset,
  rv_result_if.sink                     result,
  output logic                          retire_valid,
  output logic [rv_pkg::xlen-1:0]       retire_pc,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic                          retire_wen,
  output logic [rv_pkg::xlen-1:0]       retire_data,
  output logic [rv_pkg::xlen-1:0]       retire_next_pc,
  output logic                          retire_illegal,
  input  logic                          retire_ready,
  output logic                          wb_en,
  output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]       wb_data
);
  assign result.ready = !retire_valid || retire_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else if (result.ready) begin
      retire_valid <= result.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (result.valid && result.ready) begin
      retire_pc      <= result.pc;
      retire_rd      <= result.rd;
      retire_wen     <= result.wen;
      retire_data    <= result.data;
      retire_next_pc <= result.next_pc;
      retire_illegal <= result.illegal;
    end
  end

  // architectural write happens only as the result leaves
  assign wb_en   = retire_valid && retire_ready && retire_wen;
  assign wb_rd   = retire_rd;
  assign wb_data = retire_data;
endmodule

`default_nettype wire

// File: rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic [rv_pkg::xlen-1:0]       in_pc,
  input  logic [rv_pkg::xlen-1:0]       in_inst,
  output logic                          retire_valid,
  input  logic                          retire_ready,
  output logic [rv_pkg::xlen-1:0]       retire_pc,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic                          retire_wen,
  output logic [rv_pkg::xlen-1:0]       retire_data,
  output logic [rv_pkg::xlen-1:0]       retire_next_pc,
  output logic                          retire_illegal
);
  logic                          q_valid;
  logic                          q_ready;
  logic [rv_pkg::xlen-1:0]       q_pc;
  logic [rv_pkg::xlen-1:0]       q_inst;
  logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
  logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
  logic [rv_pkg::xlen-1:0]       rs1_val;
  logic [rv_pkg::xlen-1:0]       rs2_val;
  logic                          wb_en;
  logic [rv_pkg::reg_addr_w-1:0] wb_rd;
  logic [rv_pkg::xlen-1:0]       wb_data;

  rv_issue_if  issue_bus ();
  rv_result_if result_bus ();

  inst_queue u_queue (
    .clock, .reset,
    .in_valid, .in_pc, .in_inst, .in_ready,
    .q_valid, .q_pc, .q_inst, .q_ready
  );

  rv_decoder u_decoder (
    .clock, .reset,
    .q_valid, .q_pc, .q_inst, .q_ready,
    .rs1_addr, .rs2_addr, .rs1_val, .rs2_val,
    .wb_en, .wb_rd,
    .issue (issue_bus.source)
  );

  rv_regfile u_regfile (
    .clock, .reset,
    .rs1_addr, .rs2_addr, .rs1_val, .rs2_val,
    .wb_en, .wb_rd, .wb_data
  );

  rv_execute u_execute (
    .clock, .reset,
    .issue  (issue_bus.sink),
    .result (result_bus.source)
  );

  retire_port u_retire (
    .clock, .reset,
    .result (result_bus.sink),
    .retire_valid, .retire_pc, .retire_rd, .retire_wen,
    .retire_data, .retire_next_pc, .retire_illegal, .retire_ready,
    .wb_en, .wb_rd, .wb_data
  );
endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clock
);
  // 4 ns period
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end
endmodule

`default_nettype wire

// File: rv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
  input logic        clock,
  input logic        reset,
  input logic        in_valid,
  input logic        in_ready,
  input logic [31:0] in_pc,
  input logic [31:0] in_inst,
  input logic        retire_valid,
  input logic        retire_ready,
  input logic [31:0] retire_pc,
  input logic [4:0]  retire_rd,
  input logic        retire_wen,
  input logic [31:0] retire_data,
  input logic [31:0] retire_next_pc,
  input logic        retire_illegal
);
  int unsigned fail_count = 0;

  // a stalled retire keeps its whole result
  retire_hold: assert property (@(posedge clock) disable iff (reset)
    retire_valid && !retire_ready |=> retire_valid &&
      $stable({retire_pc, retire_rd, retire_wen, retire_data, retire_next_pc, retire_illegal}))
    else begin
      $error("retire outputs changed while retire_ready was low");
      fail_count++;
    end

  wen_rd_nonzero: assert property (@(posedge clock) disable iff (reset)
    retire_valid && retire_wen |-> retire_rd != 5'd0)
    else begin
      $error("retire_wen set with retire_rd equal to zero");
      fail_count++;
    end

  // offered instruction waits for in_ready
  input_hold: assert property (@(posedge clock) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable({in_pc, in_inst}))
    else begin
      $error("in_valid dropped or input data changed before acceptance");
      fail_count++;
    end
endmodule

bind rv_core_top rv_core_assertions u_checks (
  .clock, .reset, .in_valid, .in_ready, .in_pc, .in_inst,
  .retire_valid, .retire_ready, .retire_pc, .retire_rd, .retire_wen,
  .retire_data, .retire_next_pc, .retire_illegal
);

`default_nettype wire

// File: rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
  localparam int n_inst          = 400;
  localparam int cycles_per_inst = 40;
  localparam int period_ns       = 4;
  localparam int reset_cycles    = 16;

  logic        clock;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  logic [31:0] in_pc;
  logic [31:0] in_inst;
  logic        retire_valid;
  logic        retire_ready;
  logic [31:0] retire_pc;
  logic [4:0]  retire_rd;
  logic        retire_wen;
  logic [31:0] retire_data;
  logic [31:0] retire_next_pc;
  logic        retire_illegal;

  logic [31:0] lfsr;
  logic [31:0] arch [32];
  logic [31:0] sent_pc [$];
  logic [31:0] sent_inst [$];
  int unsigned sent;
  int unsigned retired;
  int unsigned errors;
  int unsigned checks;

  tb_clock clock_gen (.clock);

  rv_core_top dut0 (
    .clock, .reset, .in_valid, .in_ready, .in_pc, .in_inst,
    .retire_valid, .retire_ready, .retire_pc, .retire_rd, .retire_wen,
    .retire_data, .retire_next_pc, .retire_illegal
  );

  // galois step with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] draw(input int unsigned nbits);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < nbits; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // mostly x1..x7 so that hazards come often
  function automatic logic [4:0] pick_reg();
    logic [2:0] p;
    p = draw(3);
    if (p == 3'd0) return draw(5);
    return {2'b00, p};
  endfunction

  function automatic logic [31:0] make_inst();
    rv_pkg::inst_u w;
    logic [2:0]    cls;
    w.raw = draw(32);
    if (draw(4) == 0) begin
      // load, store, system and fence are outside the subset
      case (draw(2))
        0:       w.r.opcode = 7'b0000011;
        1:       w.r.opcode = 7'b0100011;
        2:       w.r.opcode = 7'b1110011;
        default: w.r.opcode = 7'b0001111;
      endcase
      return w.raw;
    end
    cls      = draw(3);
    w.r.rd   = pick_reg();
    w.r.rs1  = pick_reg();
    case (cls)
      3'd0, 3'd1: begin
        w.r.opcode = rv_pkg::op_reg;
        w.r.rs2    = pick_reg();
        w.r.funct7 = ((w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5) && draw(1)) ? 7'h20 : 7'h00;
      end
      3'd2, 3'd3: begin
        w.r.opcode = rv_pkg::op_imm;
        if (w.r.funct3 == 3'd1) w.r.funct7 = 7'h00;
        if (w.r.funct3 == 3'd5) w.r.funct7 = draw(1) ? 7'h20 : 7'h00;
      end
      3'd4: w.r.opcode = draw(1) ? rv_pkg::op_lui : rv_pkg::op_auipc;
      3'd5: w.r.opcode = rv_pkg::op_jal;
      3'd6: begin
        w.r.opcode = rv_pkg::op_jalr;
        w.r.funct3 = 3'd0;
      end
      default: begin
        w.r.opcode = rv_pkg::op_branch;
        w.r.rs2    = pick_reg();
        if (w.r.funct3 == 3'd2 || w.r.funct3 == 3'd3) w.r.funct3 = w.r.funct3 + 3'd4;
      end
    endcase
    return w.raw;
  endfunction

  // architectural execution of one word in program order
  task automatic model_step(
    input  logic [31:0] pc,
    input  logic [31:0] word,
    output logic [4:0]  e_rd,
    output logic        e_wen,
    output logic [31:0] e_data,
    output logic [31:0] e_next,
    output logic        e_ill
  );
    rv_pkg::inst_u w;
    logic [31:0]   a;
    logic [31:0]   rs2v;
    logic [31:0]   b;
    logic [31:0]   imm_i;
    logic [31:0]   res;
    logic [6:0]    f7;
    logic [2:0]    f3;
    logic          is_reg;
    logic          legal;
    logic          writes;
    logic          taken;
    w.raw  = word;
    a      = arch[w.r.rs1];
    rs2v   = arch[w.r.rs2];
    f3     = w.r.funct3;
    f7     = w.r.funct7;
    is_reg = (w.r.opcode == rv_pkg::op_reg);
    imm_i  = {{20{w.i.imm[11]}}, w.i.imm};
    b      = is_reg ? rs2v : imm_i;
    res    = '0;
    legal  = 1'b1;
    writes = 1'b0;
    taken  = 1'b0;
    e_next = pc + 32'd4;
    case (w.r.opcode)
      rv_pkg::op_lui: begin
        writes = 1'b1;
        res    = {w.u.imm, 12'h000};
      end
      rv_pkg::op_auipc: begin
        writes = 1'b1;
        res    = pc + {w.u.imm, 12'h000};
      end
      rv_pkg::op_jal: begin
        writes = 1'b1;
        res    = pc + 32'd4;
        e_next = pc + {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
      end
      rv_pkg::op_jalr: begin
        legal  = (f3 == 3'd0);
        writes = 1'b1;
        res    = pc + 32'd4;
        e_next = (a + imm_i) & ~32'd1;
      end
      rv_pkg::op_branch: begin
        case (f3)
          3'd0:    taken = (a == rs2v);
          3'd1:    taken = (a != rs2v);
          3'd4:    taken = ($signed(a) < $signed(rs2v));
          3'd5:    taken = ($signed(a) >= $signed(rs2v));
          3'd6:    taken = (a < rs2v);
          3'd7:    taken = (a >= rs2v);
          default: legal = 1'b0;
        endcase
        if (taken) begin
          e_next = pc + {{20{w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
        end
      end
      rv_pkg::op_imm, rv_pkg::op_reg: begin
        writes = 1'b1;
        if (is_reg) legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (f3 == 3'd1) legal = (f7 == 7'h00);
        else if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
        case (f3)
          3'd0: res = (is_reg && f7[5]) ? a - b : a + b;
          3'd1: res = a << b[4:0];
          3'd2: res = {31'b0, $signed(a) < $signed(b)};
          3'd3: res = {31'b0, a < b};
          3'd4: res = a ^ b;
          3'd5: begin
            if (f7[5]) res = $signed(a) >>> b[4:0];
            else res = a >> b[4:0];
          end
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      writes = 1'b0;
      res    = '0;
      e_next = pc + 32'd4;
    end
    e_rd   = w.r.rd;
    e_ill  = !legal;
    e_wen  = writes && (w.r.rd != 5'd0);
    e_data = res;
    if (e_wen) arch[w.r.rd] = res;
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_retire();
    logic [31:0] pc;
    logic [31:0] word;
    logic [31:0] e_data;
    logic [31:0] e_next;
    logic [4:0]  e_rd;
    logic        e_wen;
    logic        e_ill;
    if (sent_pc.size() == 0) begin
      errors++;
      $display("Error at %0t ns: an instruction retired that was never sent", $time);
      return;
    end
    pc   = sent_pc.pop_front();
    word = sent_inst.pop_front();
    model_step(pc, word, e_rd, e_wen, e_data, e_next, e_ill);
    check_value("retire_pc", retire_pc, pc);
    check_value("retire_rd", retire_rd, e_rd);
    check_value("retire_wen", retire_wen, e_wen);
    check_value("retire_data", retire_data, e_data);
    check_value("retire_next_pc", retire_next_pc, e_next);
    check_value("retire_illegal", retire_illegal, e_ill);
    retired++;
  endtask

  initial begin
    logic accepted;
    lfsr         = 32'h63ed;
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_pc        = '0;
    in_inst      = '0;
    retire_ready = 1'b0;
    sent         = 0;
    retired      = 0;
    errors       = 0;
    checks       = 0;
    for (int r = 0; r < 32; r++) begin
      arch[r] = '0;
    end
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
    while (retired < n_inst) begin
      // handshakes are judged mid-cycle where everything is settled
      @(negedge clock);
      accepted = in_valid && in_ready;
      if (accepted) begin
        sent_pc.push_back(in_pc);
        sent_inst.push_back(in_inst);
        sent++;
      end
      if (retire_valid && retire_ready) check_retire();
      @(posedge clock);
      #1;
      if (!in_valid || accepted) begin
        if (sent < n_inst && draw(2) != 0) begin
          in_valid = 1'b1;
          in_pc    = 4 * sent;
          in_inst  = make_inst();
        end else begin
          in_valid = 1'b0;
        end
      end
      retire_ready = (draw(2) != 0);
    end
    // every instruction has left, nothing may retire a second time
    check_value("retire_valid after the last retire", retire_valid, 32'd0);
    errors = errors + dut0.u_checks.fail_count;
    $display("%0d errors in %0d checks, %0d instructions retired", errors, checks, retired);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog sized for the whole instruction stream
  initial begin
    #(n_inst * cycles_per_inst * period_ns);
    $display("retirement stalled: only %0d of %0d instructions retired in time",
             retired, n_inst);
    $display("FAIL: see errors above");
    $finish;
  end
endmodule

`default_nettype wire

// File: src.f
rv_pkg.sv
rv_issue_if.sv
rv_result_if.sv
inst_queue.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
retire_port.sv
rv_core_top.sv
tb_clock.sv
rv_core_assertions.sv
rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_issue_if.sv
  - rv_result_if.sv
  - inst_queue.sv
  - rv_decoder.sv
  - rv_regfile.sv
  - rv_execute.sv
  - retire_port.sv
  - rv_core_top.sv
  - target: test
    files:
      - tb_clock.sv
      - rv_core_assertions.sv
      - rv_core_tb.sv
